// ==== flist.f ====
+incdir+tb
source/fix_seq_pkg.sv
source/msg_seq_tracker.sv
source/seq_num_fifo.sv
source/fix_seq_number_counter.sv
tb/tb_fix_seq_number_counter.sv

// ==== Bender.yml ====
package:
  name: fix_seq_number_counter

sources:
  - source/fix_seq_pkg.sv
  - source/msg_seq_tracker.sv
  - source/seq_num_fifo.sv
  - source/fix_seq_number_counter.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_fix_seq_number_counter.sv

// ==== tb/tb_fix_seq_tasks.svh ====
`ifndef TB_FIX_SEQ_TASKS_SVH
`define TB_FIX_SEQ_TASKS_SVH

// compare a queued entry against the model
task automatic check_entry(input seq_entry_t actual, input seq_entry_t expected,
                           input string what);
   checks++;
   if (actual !== expected) begin
      errors++;
      $display("Fail at time %0t: %s, got %h expected %h", $time, what, actual, expected);
   end
endtask

// compare a single status bit
task automatic check_flag(input logic actual, input logic expected, input string what);
   checks++;
   if (actual !== expected) begin
      errors++;
      $display("Fail at time %0t: %s, got %b expected %b", $time, what, actual, expected);
   end
endtask

// poll seq_valid on falling edges, bounded
task automatic wait_valid(output bit ok);
   int cycles;
   cycles = 0;
   while (seq_valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
   end
   ok = (seq_valid === 1'b1);
   if (!ok) begin
      errors++;
      $display("timeout: seq_valid did not rise within %0d cycles", TIMEOUT_CYCLES);
   end
endtask

// one message of the given type, tlast on the final beat
// random idle gaps between beats
task automatic send_message(input msg_type_t t, input int beats);
   for (int b = 0; b < beats; b++) begin
      tvalid = 1'b1;
      tlast  = (b == beats - 1);
      tuser  = random_tuser(t);
      @(negedge clk);
      if ($urandom_range(0, 3) == 0) begin
         tvalid = 1'b0;
         tlast  = 1'b0;
         @(negedge clk);
      end
   end
   tvalid = 1'b0;
   tlast  = 1'b0;
   note_end(t);
endtask

// valid beats that never close a message
task automatic send_partial(input int beats);
   for (int b = 0; b < beats; b++) begin
      tvalid = 1'b1;
      tlast  = 1'b0;
      tuser  = random_tuser(MSG_TYPE_FIX);
      @(negedge clk);
   end
   tvalid = 1'b0;
endtask

// pop one entry and compare it with the oldest expected value
task automatic read_entry();
   seq_entry_t expected;
   bit         ok;
   if (exp_q.size() == 0) begin
      errors++;
      $display("read requested but the model expects no entry");
   end else begin
      expected = exp_q.pop_front();
      wait_valid(ok);
      // no pop on an empty queue
      if (ok) begin
         check_entry(seq_num, expected, "queued sequence number");
         seq_rd = 1'b1;
         @(negedge clk);
         seq_rd = 1'b0;
      end
   end
endtask

// read every expected entry, then the queue must be empty
task automatic drain_queue();
   while (exp_q.size() > 0) begin
      read_entry();
   end
   check_flag(seq_valid, 1'b0, "seq_valid after draining");
endtask

// resend load, ack must be high for the next cycle only
task automatic load_begin(input seq_num_t v);
   resend_load  = 1'b1;
   resend_begin = v;
   @(negedge clk);
   resend_load  = 1'b0;
   resend_begin = '0;
   exp_num      = v;
   check_flag(resend_ack, 1'b1, "resend_ack in the cycle after load");
   @(negedge clk);
   check_flag(resend_ack, 1'b0, "resend_ack one cycle later");
endtask

`endif

// ==== tb/tb_fix_seq_number_counter.sv ====
module tb_fix_seq_number_counter
   import fix_seq_pkg::*;
();

   localparam int TUSER_WIDTH    = 128;
   localparam int DEPTH_BITS     = 6;
   localparam int QUEUE_DEPTH    = 2 ** DEPTH_BITS;
   localparam int TIMEOUT_CYCLES = 50;

   logic                   clk;
   logic                   reset;
   logic                   tvalid;
   logic                   tlast;
   logic [TUSER_WIDTH-1:0] tuser;
   logic                   resend_load;
   seq_num_t               resend_begin;
   logic                   resend_ack;
   logic                   seq_valid;
   seq_entry_t             seq_num;
   logic                   seq_rd;

   int errors;
   int checks;

   // reference model holding the current number and expected queue contents
   seq_num_t   exp_num;
   seq_entry_t exp_q[$];

   initial clk = 1'b0;
   always #4 clk = ~clk;

   fix_seq_number_counter #(
      .TUSER_WIDTH (TUSER_WIDTH),
      .DEPTH_BITS  (DEPTH_BITS)
   ) dut (
      .clk          (clk),
      .reset        (reset),
      .tvalid       (tvalid),
      .tlast        (tlast),
      .tuser        (tuser),
      .resend_load  (resend_load),
      .resend_begin (resend_begin),
      .resend_ack   (resend_ack),
      .seq_valid    (seq_valid),
      .seq_num      (seq_num),
      .seq_rd       (seq_rd)
   );

   // bcd to binary with digit 0 in the lowest nibble
   function automatic longint bcd_to_int(input seq_num_t b);
      longint v;
      v = 0;
      for (int i = SEQ_DIGITS - 1; i >= 0; i--) begin
         v = v * 10 + b[i*4 +: 4];
      end
      return v;
   endfunction

   function automatic seq_num_t int_to_bcd(input longint v);
      seq_num_t b;
      for (int i = 0; i < SEQ_DIGITS; i++) begin
         b[i*4 +: 4] = bcd_digit_t'(v % 10);
         v = v / 10;
      end
      return b;
   endfunction

   // eight digits wrap at 10**8
   function automatic seq_num_t bcd_plus_one(input seq_num_t b);
      return int_to_bcd((bcd_to_int(b) + 1) % 64'd100000000);
   endfunction

   // random sideband with the type field forced
   function automatic logic [TUSER_WIDTH-1:0] random_tuser(input msg_type_t t);
      logic [TUSER_WIDTH-1:0] u;
      for (int i = 0; i < TUSER_WIDTH; i++) begin
         u[i] = 1'($urandom_range(0, 1));
      end
      u[MSG_TYPE_LSB +: $bits(msg_type_t)] = t;
      return u;
   endfunction

   function automatic msg_type_t random_other_type();
      msg_type_t t;
      t = msg_type_t'($urandom_range(0, 15));
      if (t == MSG_TYPE_FIX) begin
         t = t + 4'd1;
      end
      return t;
   endfunction

   // model update at a message end
   // a full queue drops the entry
   function automatic void note_end(input msg_type_t t);
      if (t == MSG_TYPE_FIX) begin
         exp_num = bcd_plus_one(exp_num);
      end
      if (exp_q.size() < QUEUE_DEPTH) begin
         exp_q.push_back(exp_num[$bits(seq_entry_t)-1:0]);
      end
   endfunction

   `include "tb_fix_seq_tasks.svh"

   function automatic void report_test(input string name, input int errors_before);
      $display("%s finished with %0d errors", name, errors - errors_before);
   endfunction

   task automatic test_reset();
      int e0;
      e0 = errors;
      repeat (5) begin
         @(negedge clk);
         check_flag(seq_valid, 1'b0, "seq_valid after reset");
         check_flag(resend_ack, 1'b0, "resend_ack after reset");
      end
      report_test("reset", e0);
   endtask

   task automatic test_counting();
      int e0;
      e0 = errors;
      // open beats only so nothing may be queued
      send_partial(3);
      repeat (4) begin
         @(negedge clk);
         check_flag(seq_valid, 1'b0, "seq_valid without tlast");
      end
      for (int n = 0; n < 12; n++) begin
         send_message(MSG_TYPE_FIX, $urandom_range(1, 5));
      end
      drain_queue();
      report_test("counting", e0);
   endtask

   task automatic test_other_types();
      int e0;
      e0 = errors;
      for (int n = 0; n < 6; n++) begin
         send_message(random_other_type(), $urandom_range(1, 4));
         send_message(MSG_TYPE_FIX, $urandom_range(1, 4));
      end
      drain_queue();
      report_test("non-FIX types", e0);
   endtask

   task automatic test_resend();
      int e0;
      e0 = errors;
      load_begin(32'h0456_7891);
      send_message(random_other_type(), 2);
      send_message(MSG_TYPE_FIX, 3);
      // low digits carry into the hundreds
      load_begin(32'h1234_5699);
      send_message(MSG_TYPE_FIX, 1);
      send_message(random_other_type(), 1);
      drain_queue();
      report_test("resend", e0);
   endtask

   task automatic test_carry();
      int e0;
      e0 = errors;
      load_begin(32'h0099_9999);
      send_message(MSG_TYPE_FIX, 2);
      send_message(random_other_type(), 1);
      send_message(MSG_TYPE_FIX, 1);
      // all nines wraps to zero
      load_begin(32'h9999_9999);
      send_message(MSG_TYPE_FIX, 2);
      send_message(MSG_TYPE_FIX, 1);
      drain_queue();
      report_test("carry and wrap", e0);
   endtask

   task automatic test_capacity();
      int e0;
      e0 = errors;
      for (int n = 0; n < 70; n++) begin
         if ($urandom_range(0, 1) == 1) begin
            send_message(MSG_TYPE_FIX, $urandom_range(1, 2));
         end else begin
            send_message(random_other_type(), $urandom_range(1, 2));
         end
      end
      // last push lands one edge after the final end
      repeat (2) @(negedge clk);
      // exactly the first QUEUE_DEPTH entries must come back
      drain_queue();
      report_test("queue capacity", e0);
   endtask

   initial begin
      void'($urandom(32'h7b7f_806b));
      errors       = 0;
      checks       = 0;
      exp_num      = '0;
      reset        = 1'b1;
      tvalid       = 1'b0;
      tlast        = 1'b0;
      tuser        = '0;
      resend_load  = 1'b0;
      resend_begin = '0;
      seq_rd       = 1'b0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      test_reset();
      test_counting();
      test_other_types();
      test_resend();
      test_carry();
      test_capacity();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== source/fix_seq_number_counter.sv ====
module fix_seq_number_counter
   import fix_seq_pkg::*;
#(
   // tuser must hold the type field at MSG_TYPE_LSB
   parameter int TUSER_WIDTH = 128,
   // queue holds 2**DEPTH_BITS entries
   parameter int DEPTH_BITS  = 6
) (
   input  logic                   clk,
   input  logic                   reset,
   // receive stream
   input  logic                   tvalid,
   input  logic                   tlast,
   input  logic [TUSER_WIDTH-1:0] tuser,
   // resend control
   input  logic                   resend_load,
   input  seq_num_t               resend_begin,
   output logic                   resend_ack,
   // sequence number queue towards the host
   output logic                   seq_valid,
   output seq_entry_t             seq_num,
   input  logic                   seq_rd
);

   // tracker to queue
   logic       push;
   seq_entry_t push_entry;

   // counting and resend handling
   msg_seq_tracker #(
      .TUSER_WIDTH (TUSER_WIDTH)
   ) u_tracker (
      .clk          (clk),
      .reset        (reset),
      .tvalid       (tvalid),
      .tlast        (tlast),
      .tuser        (tuser),
      .resend_load  (resend_load),
      .resend_begin (resend_begin),
      .resend_ack   (resend_ack),
      .push         (push),
      .push_entry   (push_entry)
   );

   // one entry per message end
   // head shows without a read delay
   seq_num_fifo #(
      .DEPTH_BITS (DEPTH_BITS)
   ) u_fifo (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_entry (push_entry),
      .pop        (seq_rd),
      .head       (seq_num),
      .not_empty  (seq_valid)
   );

endmodule

// ==== source/seq_num_fifo.sv ====
module seq_num_fifo
   import fix_seq_pkg::*;
#(
   parameter int DEPTH_BITS = 6
) (
   input  logic       clk,
   input  logic       reset,
   // write side, no full feedback
   input  logic       push,
   input  seq_entry_t push_entry,
   // read side
   input  logic       pop,
   output seq_entry_t head,
   output logic       not_empty
);

   // entry count, one bit wider than the pointers
   localparam logic [DEPTH_BITS:0] DEPTH = (DEPTH_BITS+1)'(2 ** DEPTH_BITS);

   seq_entry_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;

   logic full;
   logic wr_en;
   logic rd_en;

   assign full      = (count == DEPTH);
   assign not_empty = (count != '0);

   // push while full is dropped
   assign wr_en = push & ~full;
   assign rd_en = pop & not_empty;

   // fall-through, oldest entry always visible
   assign head = mem[rd_ptr];

   // storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= push_entry;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy
   // simultaneous push and pop leaves it unchanged
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // host only pops a visible entry
   a_no_pop_empty : assert property (
      @(posedge clk) disable iff (reset)
      pop |-> not_empty
   ) else $error("pop while the queue is empty");

   // occupancy bound
   a_count_bound : assert property (
      @(posedge clk) disable iff (reset)
      count <= DEPTH
   ) else $error("queue count above depth");

endmodule

// ==== source/msg_seq_tracker.sv ====
module msg_seq_tracker
   import fix_seq_pkg::*;
#(
   parameter int TUSER_WIDTH = 128
) (
   input  logic                   clk,
   input  logic                   reset,
   // receive stream without back-pressure
   input  logic                   tvalid,
   input  logic                   tlast,
   input  logic [TUSER_WIDTH-1:0] tuser,
   // resend request from the host
   input  logic                   resend_load,
   input  seq_num_t               resend_begin,
   output logic                   resend_ack,
   // towards the queue
   output logic                   push,
   output seq_entry_t             push_entry
);

   localparam int DW = $bits(bcd_digit_t);

   // type field must fit inside tuser
   if (TUSER_WIDTH < MSG_TYPE_LSB + $bits(msg_type_t)) begin : g_width_check
      $error("tuser too narrow to carry the message type field");
   end

   msg_type_t  msg_type;
   logic       msg_end;
   logic       fix_end;

   // counter digits with digit 0 least significant
   bcd_digit_t digit_q    [SEQ_DIGITS];
   bcd_digit_t digit_inc  [SEQ_DIGITS];
   bcd_digit_t digit_next [SEQ_DIGITS];

   // carry into each digit during an increment
   logic [SEQ_DIGITS-1:0] carry;

   // type field of the current beat
   assign msg_type = tuser[MSG_TYPE_LSB +: $bits(msg_type_t)];

   // a message end needs a valid beat with tlast
   assign msg_end = tvalid & tlast;
   assign fix_end = msg_end & (msg_type == MSG_TYPE_FIX);

   // ripple decimal carry
   // digit 0 always sees a carry in
   always_comb begin
      carry[0] = 1'b1;
      for (int i = 1; i < SEQ_DIGITS; i++) begin
         carry[i] = carry[i-1] & (digit_q[i-1] == BCD_MAX_DIGIT);
      end
   end

   // plus one on every digit that sees a carry
   // a nine rolls over to zero and all nines wrap the whole counter
   always_comb begin
      for (int i = 0; i < SEQ_DIGITS; i++) begin
         if (!carry[i]) begin
            digit_inc[i] = digit_q[i];
         end else if (digit_q[i] == BCD_MAX_DIGIT) begin
            digit_inc[i] = '0;
         end else begin
            digit_inc[i] = digit_q[i] + 4'd1;
         end
      end
   end

   // next counter value
   // resend load wins over a FIX increment in the same cycle
   always_comb begin
      for (int i = 0; i < SEQ_DIGITS; i++) begin
         if (resend_load) begin
            digit_next[i] = resend_begin[i*DW +: DW];
         end else if (fix_end) begin
            digit_next[i] = digit_inc[i];
         end else begin
            digit_next[i] = digit_q[i];
         end
      end
   end

   // counter and strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < SEQ_DIGITS; i++) begin
            digit_q[i] <= '0;
         end
         push       <= 1'b0;
         resend_ack <= 1'b0;
      end else begin
         for (int i = 0; i < SEQ_DIGITS; i++) begin
            digit_q[i] <= digit_next[i];
         end
         // every message end gets queued whether FIX or not
         push       <= msg_end;
         resend_ack <= resend_load;
      end
   end

   // entry follows the counter as updated on this edge
   always_ff @(posedge clk) begin
      for (int i = 0; i < ENTRY_DIGITS; i++) begin
         push_entry[i*DW +: DW] <= digit_next[i];
      end
   end

   // digits stay decimal and so the host must load BCD begin values
   for (genvar g = 0; g < SEQ_DIGITS; g++) begin : g_digit_chk
      a_digit_bcd : assert property (
         @(posedge clk) disable iff (reset)
         digit_q[g] <= BCD_MAX_DIGIT
      ) else $error("digit %0d left the decimal range", g);
   end

endmodule

// ==== source/fix_seq_pkg.sv ====
package fix_seq_pkg;

   // one decimal digit, 0 to 9 in a nibble
   typedef logic [3:0] bcd_digit_t;

   // largest legal digit value
   localparam bcd_digit_t BCD_MAX_DIGIT = 4'd9;

   // digits held by the session counter
   localparam int SEQ_DIGITS = 8;

   // low digits kept per queued entry
   localparam int ENTRY_DIGITS = 6;

   // full sequence number
   // digit 0 sits in the lowest nibble
   typedef logic [SEQ_DIGITS*$bits(bcd_digit_t)-1:0] seq_num_t;

   // queued entry, low ENTRY_DIGITS digits only
   typedef logic [ENTRY_DIGITS*$bits(bcd_digit_t)-1:0] seq_entry_t;

   // message type field carried in tuser
   typedef logic [3:0] msg_type_t;

   // position of the type field inside tuser
   localparam int MSG_TYPE_LSB = 32;

   // type code of a FIX message
   // other codes are passed through without counting
   localparam msg_type_t MSG_TYPE_FIX = 4'd2;

endpackage
